// File: mem_wb_top.f
verilog/mips_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_stage_reg.sv
verilog/load_align.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/gpr_file.sv
verilog/mem_wb_top.sv
tb/mem_wb_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mem_wb_top testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_wb_top_tb -f mem_wb_top.f &&
./obj_dir/Vmem_wb_top_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/mem_wb_top_tb.sv
// Memory and writeback testbench
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_GPR      = 32;
    localparam int N_ALU        = 8;
    localparam int N_LOAD       = 26;
    localparam int N_LWLR       = 16;
    localparam int N_RAND       = 40;
    localparam int N_INSTR      = N_ALU + N_LOAD + N_LWLR + N_RAND;
    // data delay 3, commit stall 4, plus pipeline slack
    localparam int WORST_CPI    = 12;
    localparam int EXTRA_CYCLES = RESET_CYCLES + 4 * (NUM_GPR + 10);
    localparam int WATCHDOG_CYCLES = N_INSTR * WORST_CPI + EXTRA_CYCLES;
    localparam logic [31:0] LOAD_BASE = 32'h8000_2000;

    logic                   clk;
    logic                   rst;
    logic                   in_valid_i;
    pipe_pkg::ex_mem_t      in_op_i;
    mips_isa_pkg::word_t    data_rdata_i;
    logic                   data_data_ok_i;
    logic                   commit_ready_i;
    mips_isa_pkg::gpr_num_t rd_num_i;
    logic                   in_allowin_o;
    logic                   data_req_o;
    mips_isa_pkg::word_t    data_addr_o;
    logic                   fwd_en_o;
    mips_isa_pkg::gpr_num_t fwd_num_o;
    mips_isa_pkg::word_t    fwd_data_o;
    mips_isa_pkg::word_t    rd_data_o;
    pipe_pkg::commit_t      trace_o;

    // testbench state
    mips_isa_pkg::word_t    mem_model [16];
    mips_isa_pkg::word_t    ref_gpr [NUM_GPR];
    pipe_pkg::ex_mem_t      issue_q [$];
    pipe_pkg::commit_t      exp_q [$];
    mips_isa_pkg::word_t    addr_q [$];
    logic                   pend_valid;
    int                     pend_cnt;
    logic [3:0]             pend_idx;
    logic                   stall_mode;
    int                     stall_left;
    logic                   saw_stall;
    logic                   fwd_prev;
    mips_isa_pkg::gpr_num_t rd_sel;
    mips_isa_pkg::word_t    next_pc;
    logic [31:0]            rng_state;

    mem_wb_top #(
        .NUM_GPR(NUM_GPR)
    ) mem_wb_top_inst (
        .clk           (clk),
        .rst           (rst),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .data_rdata_i  (data_rdata_i),
        .data_data_ok_i(data_data_ok_i),
        .commit_ready_i(commit_ready_i),
        .rd_num_i      (rd_num_i),
        .in_allowin_o  (in_allowin_o),
        .data_req_o    (data_req_o),
        .data_addr_o   (data_addr_o),
        .fwd_en_o      (fwd_en_o),
        .fwd_num_o     (fwd_num_o),
        .fwd_data_o    (fwd_data_o),
        .rd_data_o     (rd_data_o),
        .trace_o       (trace_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic mips_isa_pkg::gpr_num_t pick_dest();
        return 5'(1 + next_rand() % 31);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns %s: got %08h, expected %08h",
                                $time, what, got, exp));
        end
    endtask

    // expected write value from the load rules and memory contents
    function automatic mips_isa_pkg::word_t ref_result(input pipe_pkg::ex_mem_t x);
        mips_isa_pkg::word_t w;
        mips_isa_pkg::word_t r;
        int                  o;
        int                  k;
        w = mem_model[x.addr[5:2]];
        o = int'(x.addr[1:0]);
        r = x.rt_data;
        case (x.load_op)
            mips_isa_pkg::op_lb:  r = {{24{w[8*o+7]}}, w[8*o +: 8]};
            mips_isa_pkg::op_lbu: r = {24'h0, w[8*o +: 8]};
            mips_isa_pkg::op_lh:  r = {{16{w[8*o+15]}}, w[8*o +: 16]};
            mips_isa_pkg::op_lhu: r = {16'h0, w[8*o +: 16]};
            mips_isa_pkg::op_lw:  r = w;
            mips_isa_pkg::op_lwl: begin
                // low o+1 memory bytes land in the top of rt
                for (k = 0; k <= o; k++) begin
                    r[8*(3-o+k) +: 8] = w[8*k +: 8];
                end
            end
            mips_isa_pkg::op_lwr: begin
                // memory bytes from the offset up land in the bottom of rt
                for (k = o; k < 4; k++) begin
                    r[8*(k-o) +: 8] = w[8*k +: 8];
                end
            end
            default: r = x.alu_res;
        endcase
        return r;
    endfunction

    task automatic queue_op(input mips_isa_pkg::gpr_num_t dest,
                            input mips_isa_pkg::load_op_e op,
                            input mips_isa_pkg::word_t addr,
                            input mips_isa_pkg::word_t alu,
                            input mips_isa_pkg::word_t rt);
        pipe_pkg::ex_mem_t x;
        x.pc      = next_pc;
        x.dest    = dest;
        x.load_op = op;
        x.addr    = addr;
        x.alu_res = alu;
        x.rt_data = rt;
        next_pc   = next_pc + 32'd4;
        issue_q.push_back(x);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one clock cycle that drives at the falling edge and checks settled outputs
    ////////////////////////////////////////////////////////////////////////////

    task automatic cycle();
        pipe_pkg::ex_mem_t x;
        pipe_pkg::commit_t e;
        logic              exp_fwd;
        @(negedge clk);
        data_data_ok_i = 1'b0;
        data_rdata_i   = next_rand();
        if (pend_valid) begin
            if (pend_cnt == 1) begin
                data_data_ok_i = 1'b1;
                data_rdata_i   = mem_model[pend_idx];
                pend_valid     = 1'b0;
            end else begin
                pend_cnt = pend_cnt - 1;
            end
        end
        if (stall_left > 0) begin
            commit_ready_i = 1'b0;
            stall_left     = stall_left - 1;
        end else begin
            commit_ready_i = 1'b1;
            if (stall_mode && ((next_rand() & 32'h3) == 32'h0)) begin
                stall_left = 1 + int'(next_rand() % 4);
            end
        end
        in_valid_i = (issue_q.size() != 0);
        in_op_i    = '0;
        if (in_valid_i) begin
            in_op_i = issue_q[0];
        end
        rd_num_i = rd_sel;
        #1;
        exp_fwd = 1'b0;
        if (trace_o.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("commit trace fired with no instruction outstanding");
            end
            exp_fwd = (exp_q[0].wnum != '0);
            check_value("trace pc", trace_o.pc, exp_q[0].pc);
            check_value("trace register", 32'(trace_o.wnum), 32'(exp_q[0].wnum));
            check_value("trace data", trace_o.wdata, exp_q[0].wdata);
            if (exp_q[0].wnum != '0) begin
                ref_gpr[exp_q[0].wnum] = exp_q[0].wdata;
            end
            void'(exp_q.pop_front());
        end
        // forwarding is enabled one cycle before each commit that writes a register
        check_value("forward enable", 32'(fwd_prev), 32'(exp_fwd));
        if (fwd_en_o) begin
            if (exp_q.size() == 0) begin
                abort_run("forwarding enabled with no instruction outstanding");
            end
            check_value("forward register", 32'(fwd_num_o), 32'(exp_q[0].wnum));
            check_value("forward data", fwd_data_o, exp_q[0].wdata);
        end
        fwd_prev = fwd_en_o;
        if (data_req_o) begin
            if (pend_valid || addr_q.size() == 0) begin
                abort_run("data request issued with no load ready for it");
            end
            check_value("data address", data_addr_o, addr_q[0]);
            void'(addr_q.pop_front());
            pend_valid = 1'b1;
            pend_idx   = data_addr_o[5:2];
            pend_cnt   = 1 + int'(next_rand() % 3);
        end
        if (in_valid_i && !in_allowin_o) begin
            saw_stall = 1'b1;
        end
        if (in_valid_i && in_allowin_o) begin
            x       = issue_q.pop_front();
            e.valid = 1'b1;
            e.pc    = x.pc;
            e.wnum  = x.dest;
            e.wdata = ref_result(x);
            exp_q.push_back(e);
            if (x.load_op != mips_isa_pkg::op_none) begin
                addr_q.push_back({x.addr[31:2], 2'b00});
            end
        end
    endtask

    task automatic drain();
        while (issue_q.size() != 0 || exp_q.size() != 0) begin
            cycle();
        end
    endtask

    task automatic check_regs();
        int i;
        for (i = 0; i < NUM_GPR; i++) begin
            rd_sel = 5'(i);
            cycle();
            check_value($sformatf("register r%0d", i), rd_data_o, ref_gpr[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_and_check();
        rst = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        #1;
        check_value("data_req after reset", 32'(data_req_o), 32'd0);
        check_value("fwd_en after reset", 32'(fwd_en_o), 32'd0);
        check_value("trace valid after reset", 32'(trace_o.valid), 32'd0);
        check_value("in_allowin after reset", 32'(in_allowin_o), 32'd1);
    endtask

    task automatic test_alu();
        int                     i;
        mips_isa_pkg::gpr_num_t d;
        $display("ALU pass-through test");
        for (i = 0; i < N_ALU; i++) begin
            d = (i == 3) ? 5'd0 : 5'(i * 7 + 1);
            queue_op(d, mips_isa_pkg::op_none, next_rand(), next_rand(), next_rand());
        end
        drain();
        check_regs();
    endtask

    task automatic test_loads();
        int                  w;
        int                  o;
        mips_isa_pkg::word_t a;
        $display("byte, halfword and word load test");
        for (w = 0; w < 2; w++) begin
            a = LOAD_BASE + 32'(8 * w + 4);
            for (o = 0; o < 4; o++) begin
                queue_op(pick_dest(), mips_isa_pkg::op_lb, a + 32'(o), next_rand(), next_rand());
                queue_op(pick_dest(), mips_isa_pkg::op_lbu, a + 32'(o), next_rand(), next_rand());
                if (o % 2 == 0) begin
                    queue_op(pick_dest(), mips_isa_pkg::op_lh, a + 32'(o), next_rand(),
                             next_rand());
                    queue_op(pick_dest(), mips_isa_pkg::op_lhu, a + 32'(o), next_rand(),
                             next_rand());
                end
            end
            queue_op(pick_dest(), mips_isa_pkg::op_lw, a, next_rand(), next_rand());
        end
        drain();
        check_regs();
    endtask

    task automatic test_lwl_lwr();
        int                  w;
        int                  o;
        mips_isa_pkg::word_t a;
        $display("lwl and lwr merge test");
        for (w = 0; w < 2; w++) begin
            a = LOAD_BASE + 32'(20 + 16 * w);
            for (o = 0; o < 4; o++) begin
                queue_op(pick_dest(), mips_isa_pkg::op_lwl, a + 32'(o), next_rand(), next_rand());
                queue_op(pick_dest(), mips_isa_pkg::op_lwr, a + 32'(o), next_rand(), next_rand());
            end
        end
        drain();
        check_regs();
    endtask

    task automatic test_backpressure();
        int                     i;
        mips_isa_pkg::load_op_e op;
        mips_isa_pkg::word_t    a;
        $display("random back-pressure test");
        saw_stall  = 1'b0;
        stall_mode = 1'b1;
        for (i = 0; i < N_RAND; i++) begin
            op = mips_isa_pkg::load_op_e'(3'(next_rand() % 8));
            a  = LOAD_BASE | (next_rand() & 32'h0000_003f);
            // halfword loads stay aligned
            if (op == mips_isa_pkg::op_lh || op == mips_isa_pkg::op_lhu) begin
                a[0] = 1'b0;
            end
            queue_op(5'(next_rand() % 32), op, a, next_rand(), next_rand());
        end
        drain();
        stall_mode = 1'b0;
        if (!saw_stall) begin
            abort_run("in_allowin_o never dropped while the pipeline was full");
        end
        check_regs();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog timeout, the pipeline did not finish all instructions");
    end

    initial begin
        int i;
        clk            = 1'b0;
        rst            = 1'b0;
        in_valid_i     = 1'b0;
        in_op_i        = '0;
        data_rdata_i   = '0;
        data_data_ok_i = 1'b0;
        commit_ready_i = 1'b1;
        rd_num_i       = '0;
        rng_state      = 32'd53;
        pend_valid     = 1'b0;
        pend_cnt       = 0;
        pend_idx       = '0;
        stall_mode     = 1'b0;
        stall_left     = 0;
        saw_stall      = 1'b0;
        fwd_prev       = 1'b0;
        rd_sel         = '0;
        next_pc        = 32'hbfc0_0000;
        for (i = 0; i < 16; i++) begin
            mem_model[i] = ((32'(i) + 32'd1) * 32'h9e37_79b9) ^ (32'(i) << 11);
        end
        // words with known sign bits in every byte and halfword
        mem_model[1] = 32'h80ff_7f01;
        mem_model[3] = 32'h7f80_01fe;
        for (i = 0; i < NUM_GPR; i++) begin
            ref_gpr[i] = '0;
        end
        reset_and_check();
        test_alu();
        test_loads();
        test_lwl_lwr();
        test_backpressure();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mem_wb_top.sv
// Memory and writeback pipeline tail
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top #(
    parameter int NUM_GPR = 32
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         in_valid_i,
    input  wire pipe_pkg::ex_mem_t      in_op_i,
    input  wire mips_isa_pkg::word_t    data_rdata_i,
    input  wire                         data_data_ok_i,
    input  wire                         commit_ready_i,
    input  wire mips_isa_pkg::gpr_num_t rd_num_i,
    output logic                        in_allowin_o,
    output logic                        data_req_o,
    output mips_isa_pkg::word_t         data_addr_o,
    output logic                        fwd_en_o,
    output mips_isa_pkg::gpr_num_t      fwd_num_o,
    output mips_isa_pkg::word_t         fwd_data_o,
    output mips_isa_pkg::word_t         rd_data_o,
    output pipe_pkg::commit_t           trace_o
);

    logic                   mem_valid;
    pipe_pkg::mem_wb_t      mem_out;
    logic                   wb_allowin;
    logic                   wr_en;
    mips_isa_pkg::gpr_num_t wr_num;
    mips_isa_pkg::word_t    wr_data;

    mem_stage mem_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_op_i     (in_op_i),
        .wb_allowin_i(wb_allowin),
        .in_allowin_o(in_allowin_o),
        .data_req_o  (data_req_o),
        .data_addr_o (data_addr_o),
        .out_valid_o (mem_valid),
        .out_o       (mem_out)
    );

    wb_stage wb_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .in_valid_i    (mem_valid),
        .in_i          (mem_out),
        .data_rdata_i  (data_rdata_i),
        .data_data_ok_i(data_data_ok_i),
        .commit_ready_i(commit_ready_i),
        .allowin_o     (wb_allowin),
        .fwd_num_o     (fwd_num_o),
        .fwd_data_o    (fwd_data_o),
        .fwd_en_o      (fwd_en_o),
        .wr_en_o       (wr_en),
        .wr_num_o      (wr_num),
        .wr_data_o     (wr_data),
        .trace_o       (trace_o)
    );

    gpr_file #(
        .NUM_GPR(NUM_GPR)
    ) gpr_file_inst (
        .clk      (clk),
        .rst      (rst),
        .wr_en_i  (wr_en),
        .wr_num_i (wr_num),
        .wr_data_i(wr_data),
        .rd_num_i (rd_num_i),
        .rd_data_o(rd_data_o)
    );

endmodule

`default_nettype wire

// File: verilog/gpr_file.sv
// General-purpose register file
`timescale 1ns/1ps
`default_nettype none

module gpr_file #(
    parameter int NUM_GPR = 32
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en_i,
    input  wire mips_isa_pkg::gpr_num_t wr_num_i,
    input  wire mips_isa_pkg::word_t    wr_data_i,
    input  wire mips_isa_pkg::gpr_num_t rd_num_i,
    output mips_isa_pkg::word_t         rd_data_o
);

    localparam int IDX_W = $clog2(NUM_GPR);

    mips_isa_pkg::word_t regs [NUM_GPR];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_num_i != '0)) begin
            regs[wr_num_i[IDX_W-1:0]] <= wr_data_i;
        end
    end

    // r0 reads as zero
    assign rd_data_o = (rd_num_i == '0) ? '0 : regs[rd_num_i[IDX_W-1:0]];

    no_r0_write: assert property (
        @(posedge clk) disable iff (!rst)
        wr_en_i |-> (wr_num_i != '0)
    ) else $error("write enable raised for r0");

endmodule

`default_nettype wire

// File: verilog/wb_stage.sv
// Writeback stage
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid_i,
    input  wire pipe_pkg::mem_wb_t in_i,
    input  wire mips_isa_pkg::word_t data_rdata_i,
    input  wire                    data_data_ok_i,
    input  wire                    commit_ready_i,
    output logic                   allowin_o,
    output mips_isa_pkg::gpr_num_t fwd_num_o,
    output mips_isa_pkg::word_t    fwd_data_o,
    output logic                   fwd_en_o,
    output logic                   wr_en_o,
    output mips_isa_pkg::gpr_num_t wr_num_o,
    output mips_isa_pkg::word_t    wr_data_o,
    output pipe_pkg::commit_t      trace_o
);

    pipe_pkg::mem_wb_t   item_q;
    logic                item_valid;
    logic                data_got;
    mips_isa_pkg::word_t rdata_hold;
    mips_isa_pkg::word_t rdata;
    mips_isa_pkg::word_t load_data;
    mips_isa_pkg::word_t result;
    logic                ready;
    logic                retire;

    pipe_stage_reg #(
        .payload_t(pipe_pkg::mem_wb_t)
    ) stage_reg_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_i),
        .ready_i      (ready),
        .out_allowin_i(commit_ready_i),
        .allowin_o    (allowin_o),
        .out_valid_o  (item_valid),
        .q_o          (item_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // load data capture
    ////////////////////////////////////////////////////////////////////////////

    // data_ok is a single pulse, keep the word if commit is stalled
    always_ff @(posedge clk) begin
        if (!rst) begin
            data_got <= 1'b0;
        end else if (allowin_o) begin
            data_got <= 1'b0;
        end else if (data_data_ok_i) begin
            data_got <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_data_ok_i) begin
            rdata_hold <= data_rdata_i;
        end
    end

    assign rdata = data_got ? rdata_hold : data_rdata_i;
    assign ready = !item_q.mem_req || data_data_ok_i || data_got;

    load_align load_align_inst (
        .rdata_i   (rdata),
        .rt_data_i (item_q.rt_data),
        .align_i   (item_q.align),
        .load_sel_i(item_q.load_sel),
        .data_o    (load_data)
    );

    assign result = item_q.mem_req ? load_data : item_q.final_res;
    assign retire = item_valid && ready && commit_ready_i;

    // register write and forwarding
    assign wr_en_o    = retire && (item_q.dest != '0);
    assign wr_num_o   = item_q.dest;
    assign wr_data_o  = result;
    assign fwd_en_o   = wr_en_o;
    assign fwd_num_o  = item_q.dest;
    assign fwd_data_o = result;

    // commit trace, one cycle behind retire
    always_ff @(posedge clk) begin
        if (!rst) begin
            trace_o.valid <= 1'b0;
        end else begin
            trace_o.valid <= retire;
            if (retire) begin
                trace_o.pc    <= item_q.pc;
                trace_o.wnum  <= item_q.dest;
                trace_o.wdata <= result;
            end
        end
    end

    data_ok_for_load: assert property (
        @(posedge clk) disable iff (!rst)
        data_data_ok_i |-> (item_valid && item_q.mem_req && !data_got)
    ) else $error("load data returned with no load waiting");

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
// Memory stage
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid_i,
    input  wire pipe_pkg::ex_mem_t in_op_i,
    input  wire                    wb_allowin_i,
    output logic                   in_allowin_o,
    output logic                   data_req_o,
    output mips_isa_pkg::word_t    data_addr_o,
    output logic                   out_valid_o,
    output pipe_pkg::mem_wb_t      out_o
);

    pipe_pkg::ex_mem_t       op_q;
    mips_isa_pkg::load_sel_t load_sel;
    logic                    is_load;

    // always ready, bus takes the request at once
    pipe_stage_reg #(
        .payload_t(pipe_pkg::ex_mem_t)
    ) stage_reg_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_op_i),
        .ready_i      (1'b1),
        .out_allowin_i(wb_allowin_i),
        .allowin_o    (in_allowin_o),
        .out_valid_o  (out_valid_o),
        .q_o          (op_q)
    );

    assign is_load = (op_q.load_op != mips_isa_pkg::op_none);

    // load select from opcode and byte offset
    always_comb begin
        load_sel = '0;
        case (op_q.load_op)
            mips_isa_pkg::op_lb:  load_sel[mips_isa_pkg::SEL_LB]  = 1'b1;
            mips_isa_pkg::op_lbu: load_sel[mips_isa_pkg::SEL_LBU] = 1'b1;
            mips_isa_pkg::op_lh:  load_sel[mips_isa_pkg::SEL_LH]  = 1'b1;
            mips_isa_pkg::op_lhu: load_sel[mips_isa_pkg::SEL_LHU] = 1'b1;
            mips_isa_pkg::op_lw:  load_sel[mips_isa_pkg::SEL_LW]  = 1'b1;
            mips_isa_pkg::op_lwl: begin
                case (op_q.addr[1:0])
                    2'd0:    load_sel[mips_isa_pkg::SEL_L0] = 1'b1;
                    2'd1:    load_sel[mips_isa_pkg::SEL_L1] = 1'b1;
                    2'd2:    load_sel[mips_isa_pkg::SEL_L2] = 1'b1;
                    default: load_sel[mips_isa_pkg::SEL_LW] = 1'b1;
                endcase
            end
            mips_isa_pkg::op_lwr: begin
                case (op_q.addr[1:0])
                    2'd0:    load_sel[mips_isa_pkg::SEL_LW] = 1'b1;
                    2'd1:    load_sel[mips_isa_pkg::SEL_R1] = 1'b1;
                    2'd2:    load_sel[mips_isa_pkg::SEL_R2] = 1'b1;
                    default: load_sel[mips_isa_pkg::SEL_R3] = 1'b1;
                endcase
            end
            default: load_sel = '0;
        endcase
    end

    // request goes out in the cycle the load moves to writeback
    assign data_req_o  = out_valid_o && is_load && wb_allowin_i;
    assign data_addr_o = {op_q.addr[31:2], 2'b00};

    always_comb begin
        out_o.pc        = op_q.pc;
        out_o.dest      = op_q.dest;
        out_o.mem_req   = is_load;
        out_o.align     = op_q.addr[1:0];
        out_o.load_sel  = load_sel;
        out_o.final_res = op_q.alu_res;
        out_o.rt_data   = op_q.rt_data;
    end

endmodule

`default_nettype wire

// File: verilog/load_align.sv
// Load data alignment
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire mips_isa_pkg::word_t     rdata_i,
    input  wire mips_isa_pkg::word_t     rt_data_i,
    input  wire [1:0]                    align_i,
    input  wire mips_isa_pkg::load_sel_t load_sel_i,
    output mips_isa_pkg::word_t          data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        byte_sign;
    logic        half_sign;

    // byte and halfword named by the offset
    always_comb begin
        case (align_i)
            2'd0:    byte_sel = rdata_i[7:0];
            2'd1:    byte_sel = rdata_i[15:8];
            2'd2:    byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
    end

    assign half_sel  = align_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    assign byte_sign = load_sel_i[mips_isa_pkg::SEL_LB] && byte_sel[7];
    assign half_sign = load_sel_i[mips_isa_pkg::SEL_LH] && half_sel[15];

    // lwl fills rt from the top, lwr from the bottom
    always_comb begin
        if (load_sel_i[mips_isa_pkg::SEL_LB] || load_sel_i[mips_isa_pkg::SEL_LBU]) begin
            data_o = {{24{byte_sign}}, byte_sel};
        end else if (load_sel_i[mips_isa_pkg::SEL_LH] || load_sel_i[mips_isa_pkg::SEL_LHU]) begin
            data_o = {{16{half_sign}}, half_sel};
        end else if (load_sel_i[mips_isa_pkg::SEL_L0]) begin
            data_o = {rdata_i[7:0], rt_data_i[23:0]};
        end else if (load_sel_i[mips_isa_pkg::SEL_L1]) begin
            data_o = {rdata_i[15:0], rt_data_i[15:0]};
        end else if (load_sel_i[mips_isa_pkg::SEL_L2]) begin
            data_o = {rdata_i[23:0], rt_data_i[7:0]};
        end else if (load_sel_i[mips_isa_pkg::SEL_R1]) begin
            data_o = {rt_data_i[31:24], rdata_i[31:8]};
        end else if (load_sel_i[mips_isa_pkg::SEL_R2]) begin
            data_o = {rt_data_i[31:16], rdata_i[31:16]};
        end else if (load_sel_i[mips_isa_pkg::SEL_R3]) begin
            data_o = {rt_data_i[31:8], rdata_i[31:24]};
        end else begin
            // plain word, also lwl at 3 and lwr at 0
            data_o = rdata_i;
        end
    end

    always_comb begin
        sel_onehot: assert ($isunknown(load_sel_i) || $onehot0(load_sel_i))
            else $error("load select is not one-hot");
    end

endmodule

`default_nettype wire

// File: verilog/pipe_stage_reg.sv
// Generic pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           in_valid_i,
    input  wire payload_t in_data_i,
    input  wire           ready_i,
    input  wire           out_allowin_i,
    output logic          allowin_o,
    output logic          out_valid_o,
    output payload_t      q_o
);

    logic has_data;

    // slot frees up when the item is done and the next stage takes it
    assign allowin_o   = !has_data || (ready_i && out_allowin_i);
    assign out_valid_o = has_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            has_data <= 1'b0;
        end else if (allowin_o) begin
            has_data <= in_valid_i;
        end
    end

    // empty slot holds zeros
    always_ff @(posedge clk) begin
        if (allowin_o) begin
            if (in_valid_i) begin
                q_o <= in_data_i;
            end else begin
                q_o <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // an offered item waits unchanged until this stage takes it
    offer_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (in_valid_i && !allowin_o) |=> (in_valid_i && $stable(in_data_i))
    ) else $error("offered payload changed before it was taken");

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
// Pipeline payload structs
`default_nettype none

package pipe_pkg;

    // executed instruction entering the memory stage
    typedef struct packed {
        mips_isa_pkg::word_t    pc;
        mips_isa_pkg::gpr_num_t dest;
        mips_isa_pkg::load_op_e load_op;
        mips_isa_pkg::word_t    addr;
        mips_isa_pkg::word_t    alu_res;
        mips_isa_pkg::word_t    rt_data;
    } ex_mem_t;

    // held in writeback while load data is pending
    typedef struct packed {
        mips_isa_pkg::word_t     pc;
        mips_isa_pkg::gpr_num_t  dest;
        logic                    mem_req;
        logic [1:0]              align;
        mips_isa_pkg::load_sel_t load_sel;
        mips_isa_pkg::word_t     final_res;
        mips_isa_pkg::word_t     rt_data;
    } mem_wb_t;

    // one retired instruction
    typedef struct packed {
        logic                   valid;
        mips_isa_pkg::word_t    pc;
        mips_isa_pkg::gpr_num_t wnum;
        mips_isa_pkg::word_t    wdata;
    } commit_t;

endpackage

`default_nettype wire

// File: verilog/mips_isa_pkg.sv
// ISA types for the load path
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;

    // register number, zero means no writeback
    typedef logic [4:0] gpr_num_t;

    typedef enum logic [2:0] {
        op_none,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr
    } load_op_e;

    // bit positions in the one-hot load select
    localparam int SEL_LB  = 0;
    localparam int SEL_LBU = 1;
    localparam int SEL_LH  = 2;
    localparam int SEL_LHU = 3;
    localparam int SEL_LW  = 4;
    // lwl at offsets 0..2, lwr at offsets 1..3
    localparam int SEL_L0  = 5;
    localparam int SEL_L1  = 6;
    localparam int SEL_L2  = 7;
    localparam int SEL_R1  = 8;
    localparam int SEL_R2  = 9;
    localparam int SEL_R3  = 10;
    localparam int SEL_W   = 11;

    typedef logic [SEL_W-1:0] load_sel_t;

endpackage

`default_nettype wire
